/* rtl/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath sizing
`define RV_XLEN 32 // Data and address width
`define RV_NREGS 32 // Architectural registers x0..x31
`define RV_RADDR_W 5 // Register index width

// Base opcodes of the supported RV32I subset
`define RV_OP_ALU_R 7'b0110011 // Register-register ALU
`define RV_OP_ALU_I 7'b0010011 // Register-immediate ALU
`define RV_OP_LOAD 7'b0000011 // lw
`define RV_OP_STORE 7'b0100011 // sw
`define RV_OP_LUI 7'b0110111 // lui
`define RV_OP_BRANCH 7'b1100011 // beq, bne, blt, bge, bltu, bgeu

// Sequential PC step, one word
`define RV_PC_STEP 4

`endif

/* rtl/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

	typedef enum logic [2:0] {
		ALU_R,
		ALU_I,
		LOAD,
		STORE,
		LUI,
		BRANCH,
		OTHER // Unsupported opcode, runs as a no-op
	} instr_class_e;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		SLL,
		SLT,
		SLTU,
		XOR,
		SRL,
		SRA,
		OR,
		AND
	} alu_op_e;

	// Source of the register file write data
	typedef enum logic [1:0] {
		WB_RESULT, // RR
		WB_MEMORY, // RY
		WB_IMM // lui immediate
	} wb_sel_e;

	typedef struct packed {
		instr_class_e iclass;
		logic [`RV_RADDR_W-1:0] rs1;
		logic [`RV_RADDR_W-1:0] rs2;
		logic [`RV_RADDR_W-1:0] rd;
		logic [2:0] funct3;
		alu_op_e alu_op;
		logic [`RV_XLEN-1:0] imm; // Sign-extended I/S/B or U immediate
	} decode_t;

	typedef struct packed {
		logic load_ops; // RA and RB from the register file
		logic op2_imm; // ALU operand 2 is the immediate
		logic load_rr;
		wb_sel_e wb_sel;
		logic load_ry;
		logic rf_we;
		logic pc_update;
		logic pc_branch; // PC update follows the branch condition
	} ctrl_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] addr;
		logic rd;
	} imem_req_t;

	typedef struct packed {
		logic [`RV_XLEN-1:0] addr;
		logic rd;
		logic wr;
		logic [`RV_XLEN-1:0] wdata;
	} dmem_req_t;

endpackage

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module instr_decoder (
	input logic clk,
	input logic reset,
	input logic i_capture,
	input logic [`RV_XLEN-1:0] i_word,
	output rv_pkg::decode_t o_dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt_op; // funct7 bit 5, or immediate bit 30 for shifts
	rv_pkg::decode_t dec_next;

	assign opcode = i_word[6:0];
	assign funct3 = i_word[14:12];
	assign alt_op = i_word[30];

	always_comb begin
		dec_next = '0;
		dec_next.rs1 = i_word[19:15];
		dec_next.rs2 = i_word[24:20];
		dec_next.rd = i_word[11:7];
		dec_next.funct3 = funct3;
		dec_next.iclass = rv_pkg::OTHER;
		dec_next.alu_op = rv_pkg::ADD; // Address calculation for lw and sw

		case (opcode)
			`RV_OP_ALU_R: dec_next.iclass = rv_pkg::ALU_R;
			`RV_OP_ALU_I: begin
				dec_next.iclass = rv_pkg::ALU_I;
				dec_next.imm = {{20{i_word[31]}}, i_word[31:20]};
			end
			`RV_OP_LOAD: begin
				dec_next.iclass = rv_pkg::LOAD;
				dec_next.imm = {{20{i_word[31]}}, i_word[31:20]};
			end
			`RV_OP_STORE: begin
				dec_next.iclass = rv_pkg::STORE;
				dec_next.imm = {{20{i_word[31]}}, i_word[31:25], i_word[11:7]};
			end
			`RV_OP_LUI: begin
				dec_next.iclass = rv_pkg::LUI;
				dec_next.imm = {i_word[31:12], 12'b0};
			end
			`RV_OP_BRANCH: begin
				dec_next.iclass = rv_pkg::BRANCH;
				dec_next.imm = {{20{i_word[31]}}, i_word[7], i_word[30:25],
					i_word[11:8], 1'b0};
				dec_next.alu_op = rv_pkg::SUB;
			end
			default: dec_next.iclass = rv_pkg::OTHER;
		endcase

		// Operation select shared by the R and I forms
		if (opcode == `RV_OP_ALU_R || opcode == `RV_OP_ALU_I) begin
			case (funct3)
				3'b000: begin
					if (opcode == `RV_OP_ALU_R && alt_op)
						dec_next.alu_op = rv_pkg::SUB;
					else
						dec_next.alu_op = rv_pkg::ADD; // No subi in RV32I
				end
				3'b001: dec_next.alu_op = rv_pkg::SLL;
				3'b010: dec_next.alu_op = rv_pkg::SLT;
				3'b011: dec_next.alu_op = rv_pkg::SLTU;
				3'b100: dec_next.alu_op = rv_pkg::XOR;
				3'b101: dec_next.alu_op = alt_op ? rv_pkg::SRA : rv_pkg::SRL;
				3'b110: dec_next.alu_op = rv_pkg::OR;
				default: dec_next.alu_op = rv_pkg::AND;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_dec <= '0;
		end else if (i_capture) begin
			o_dec <= dec_next; // Held for the rest of the instruction
		end
	end

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module register_file (
	input logic clk,
	input logic reset,
	input rv_pkg::decode_t i_dec,
	input logic i_we,
	input logic [`RV_XLEN-1:0] i_wdata,
	output logic [`RV_XLEN-1:0] o_rs1_data,
	output logic [`RV_XLEN-1:0] o_rs2_data
);

	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	// Asynchronous read ports, sampled into RA and RB by the execute unit
	assign o_rs1_data = regs[i_dec.rs1];
	assign o_rs2_data = regs[i_dec.rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && i_dec.rd != '0) begin
			regs[i_dec.rd] <= i_wdata; // x0 is never written
		end
	end

	// x0 stays zero through every writeback, lui included
	a_x0_zero: assert property (@(posedge clk) disable iff (reset)
		(i_dec.rs1 == '0) |-> (o_rs1_data == '0))
		else $error("x0 read back nonzero value %h", o_rs1_data);

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_unit (
	input logic clk,
	input logic reset,
	input rv_pkg::ctrl_t i_ctrl,
	input rv_pkg::decode_t i_dec,
	input logic [`RV_XLEN-1:0] i_rs1_data,
	input logic [`RV_XLEN-1:0] i_rs2_data,
	input logic [`RV_XLEN-1:0] i_load_data,
	output logic [`RV_XLEN-1:0] o_pc,
	output logic [`RV_XLEN-1:0] o_dmem_addr,
	output logic [`RV_XLEN-1:0] o_store_data,
	output logic [`RV_XLEN-1:0] o_wb_data
);

	logic [`RV_XLEN-1:0] ra;
	logic [`RV_XLEN-1:0] rb;
	logic [`RV_XLEN-1:0] rr; // ALU result, also the load/store address
	logic [`RV_XLEN-1:0] ry; // Load data
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] op2;
	logic [`RV_XLEN-1:0] alu_result;
	logic [4:0] shamt;
	logic take_branch;

	assign op2 = i_ctrl.op2_imm ? i_dec.imm : rb;
	assign shamt = op2[4:0];

	always_comb begin
		case (i_dec.alu_op)
			rv_pkg::ADD: alu_result = ra + op2;
			rv_pkg::SUB: alu_result = ra - op2;
			rv_pkg::SLL: alu_result = ra << shamt;
			rv_pkg::SLT: alu_result = `RV_XLEN'($signed(ra) < $signed(op2));
			rv_pkg::SLTU: alu_result = `RV_XLEN'(ra < op2);
			rv_pkg::XOR: alu_result = ra ^ op2;
			rv_pkg::SRL: alu_result = ra >> shamt;
			rv_pkg::SRA: alu_result = $unsigned($signed(ra) >>> shamt);
			rv_pkg::OR: alu_result = ra | op2;
			rv_pkg::AND: alu_result = ra & op2;
			default: alu_result = '0;
		endcase
	end

	// Branch condition straight from the operand registers
	always_comb begin
		case (i_dec.funct3)
			3'b000: take_branch = (ra == rb); // beq
			3'b001: take_branch = (ra != rb); // bne
			3'b100: take_branch = ($signed(ra) < $signed(rb)); // blt
			3'b101: take_branch = ($signed(ra) >= $signed(rb)); // bge
			3'b110: take_branch = (ra < rb); // bltu
			3'b111: take_branch = (ra >= rb); // bgeu
			default: take_branch = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ra <= '0;
			rb <= '0;
			rr <= '0;
			ry <= '0;
			pc <= '0;
		end else begin
			if (i_ctrl.load_ops) begin
				ra <= i_rs1_data;
				rb <= i_rs2_data;
			end
			if (i_ctrl.load_rr)
				rr <= alu_result;
			if (i_ctrl.load_ry)
				ry <= i_load_data;
			if (i_ctrl.pc_update) begin
				if (i_ctrl.pc_branch && take_branch)
					pc <= pc + i_dec.imm;
				else
					pc <= pc + `RV_PC_STEP;
			end
		end
	end

	always_comb begin
		case (i_ctrl.wb_sel)
			rv_pkg::WB_MEMORY: o_wb_data = ry;
			rv_pkg::WB_IMM: o_wb_data = i_dec.imm;
			default: o_wb_data = rr;
		endcase
	end

	assign o_pc = pc;
	assign o_dmem_addr = rr;
	assign o_store_data = rb; // sw writes rs2 as a whole word

	// Branch offsets from the decoder must keep fetches on word boundaries
	a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("PC not word aligned: %h", pc);

endmodule

/* rtl/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
	input logic clk,
	input logic reset,
	input rv_pkg::decode_t i_dec,
	output rv_pkg::ctrl_t o_ctrl,
	output logic o_capture,
	output logic o_imem_rd,
	output logic o_dmem_rd,
	output logic o_dmem_wr
);

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WB
	} state_e;

	state_e state;
	state_e next_state;
	logic is_alu;
	logic is_mem;

	assign is_alu = (i_dec.iclass == rv_pkg::ALU_R) || (i_dec.iclass == rv_pkg::ALU_I);
	assign is_mem = (i_dec.iclass == rv_pkg::LOAD) || (i_dec.iclass == rv_pkg::STORE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_FETCH; // First cycle out of reset fetches address 0
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		o_ctrl = '0;
		o_ctrl.wb_sel = rv_pkg::WB_RESULT;
		o_capture = 1'b0;
		o_imem_rd = 1'b0;
		o_dmem_rd = 1'b0;
		o_dmem_wr = 1'b0;
		next_state = state;

		case (state)
			S_FETCH: begin
				o_imem_rd = 1'b1;
				o_capture = 1'b1; // Decoder latches the word at this edge
				next_state = S_DECODE;
			end
			S_DECODE: begin
				case (i_dec.iclass)
					rv_pkg::LUI: begin
						o_ctrl.wb_sel = rv_pkg::WB_IMM;
						o_ctrl.rf_we = 1'b1;
						o_ctrl.pc_update = 1'b1;
						next_state = S_FETCH;
					end
					rv_pkg::OTHER: begin
						o_ctrl.pc_update = 1'b1; // Skip over it
						next_state = S_FETCH;
					end
					default: begin
						o_ctrl.load_ops = 1'b1;
						next_state = S_EXEC;
					end
				endcase
			end
			S_EXEC: begin
				if (i_dec.iclass == rv_pkg::BRANCH) begin
					o_ctrl.pc_update = 1'b1;
					o_ctrl.pc_branch = 1'b1;
					next_state = S_FETCH;
				end else begin
					o_ctrl.load_rr = 1'b1;
					o_ctrl.op2_imm = (i_dec.iclass != rv_pkg::ALU_R);
					next_state = is_mem ? S_MEM : S_WB;
				end
			end
			S_MEM: begin
				if (i_dec.iclass == rv_pkg::STORE) begin
					o_dmem_wr = 1'b1;
					o_ctrl.pc_update = 1'b1;
					next_state = S_FETCH;
				end else begin
					o_dmem_rd = 1'b1;
					o_ctrl.load_ry = 1'b1; // Read data is valid this cycle
					next_state = S_WB;
				end
			end
			S_WB: begin
				o_ctrl.rf_we = is_alu || (i_dec.iclass == rv_pkg::LOAD);
				if (i_dec.iclass == rv_pkg::LOAD)
					o_ctrl.wb_sel = rv_pkg::WB_MEMORY;
				o_ctrl.pc_update = 1'b1;
				next_state = S_FETCH;
			end
			default: next_state = S_FETCH;
		endcase
	end

	// One data access per cycle and only for lw or sw
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		(o_dmem_rd || o_dmem_wr) |-> (o_dmem_rd != o_dmem_wr) &&
			(i_dec.iclass == (o_dmem_wr ? rv_pkg::STORE : rv_pkg::LOAD)))
		else $error("dmem strobe not matching a single lw or sw access");

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
	input logic clk,
	input logic reset,
	output rv_pkg::imem_req_t o_imem,
	input logic [`RV_XLEN-1:0] i_imem_data,
	output rv_pkg::dmem_req_t o_dmem,
	input logic [`RV_XLEN-1:0] i_dmem_rdata
);

	rv_pkg::decode_t dec;
	rv_pkg::ctrl_t ctrl;
	logic capture;
	logic imem_rd;
	logic dmem_rd;
	logic dmem_wr;
	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] wb_data;
	logic [`RV_XLEN-1:0] pc;
	logic [`RV_XLEN-1:0] dmem_addr;
	logic [`RV_XLEN-1:0] store_data;

	assign o_imem = '{addr: pc, rd: imem_rd};
	assign o_dmem = '{addr: dmem_addr, rd: dmem_rd, wr: dmem_wr, wdata: store_data};

	instr_decoder u_decoder (
		.clk(clk),
		.reset(reset),
		.i_capture(capture),
		.i_word(i_imem_data),
		.o_dec(dec)
	);

	register_file u_regs (
		.clk(clk),
		.reset(reset),
		.i_dec(dec),
		.i_we(ctrl.rf_we),
		.i_wdata(wb_data),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data)
	);

	execute_unit u_exec (
		.clk(clk),
		.reset(reset),
		.i_ctrl(ctrl),
		.i_dec(dec),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.i_load_data(i_dmem_rdata),
		.o_pc(pc),
		.o_dmem_addr(dmem_addr),
		.o_store_data(store_data),
		.o_wb_data(wb_data)
	);

	control_fsm u_ctrl (
		.clk(clk),
		.reset(reset),
		.i_dec(dec),
		.o_ctrl(ctrl),
		.o_capture(capture),
		.o_imem_rd(imem_rd),
		.o_dmem_rd(dmem_rd),
		.o_dmem_wr(dmem_wr)
	);

endmodule

/* bench/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_core;

	localparam int CYCLE_NS = 20;
	localparam int DRIVE_DELAY = 2; // Input changes after the rising edge
	localparam int RESET_CYCLES = 3;
	localparam int MEM_WORDS = 2048; // 8 KB with data from 0x1000
	localparam int MAX_INSTR_CYCLES = 5;
	localparam int LOOP_ALLOWANCE = 50;

	logic clk = 1'b0;
	logic reset = 1'b1;
	rv_pkg::imem_req_t imem_req;
	logic [`RV_XLEN-1:0] imem_data;
	rv_pkg::dmem_req_t dmem_req;
	logic [`RV_XLEN-1:0] dmem_rdata;

	logic [`RV_XLEN-1:0] mem [MEM_WORDS]; // Shared instruction and data memory
	logic [`RV_XLEN-1:0] exp_addr_q [$];
	logic [`RV_XLEN-1:0] exp_data_q [$];
	int n_prog = 0;
	int n_expected = 0;
	int stores_seen = 0;
	bit loaded = 1'b0;
	bit fetch_seen = 1'b0;

	rv_core u_dut (
		.clk(clk),
		.reset(reset),
		.o_imem(imem_req),
		.i_imem_data(imem_data),
		.o_dmem(dmem_req),
		.i_dmem_rdata(dmem_rdata)
	);

	always #(CYCLE_NS / 2) clk = ~clk;

	// Both ports answer in the same cycle, only while their read strobe is high
	assign imem_data = imem_req.rd ? mem[imem_req.addr[12:2]] : 'x;
	assign dmem_rdata = dmem_req.rd ? mem[dmem_req.addr[12:2]] : 'x;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [`RV_XLEN-1:0] expected,
		input logic [`RV_XLEN-1:0] actual);
		abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic load_cases;
		int fd;
		int n;
		string line;
		logic [7:0] tag;
		logic [`RV_XLEN-1:0] addr;
		logic [`RV_XLEN-1:0] word;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'hc0de_0000 ^ (i << 2); // Unique per word address
		fd = $fopen("bench/core_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open bench/core_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line[0] != "#") begin
				n = $sscanf(line, "%c %h %h", tag, addr, word);
				if (n == 3) begin
					case (tag)
						"P": begin
							mem[addr[12:2]] = word;
							n_prog++;
						end
						"D": mem[addr[12:2]] = word;
						"E": begin
							exp_addr_q.push_back(addr);
							exp_data_q.push_back(word);
						end
						default: abort_run("unknown tag in bench/core_cases.txt");
					endcase
				end
			end
		end
		$fclose(fd);
		n_expected = exp_addr_q.size();
	endtask

	// Compare one store with the next expected entry, then commit it
	task automatic check_store;
		logic [`RV_XLEN-1:0] exp_addr;
		logic [`RV_XLEN-1:0] exp_data;
		assert (stores_seen < n_expected)
			else abort_run("store seen after the last expected store");
		exp_addr = exp_addr_q[stores_seen];
		exp_data = exp_data_q[stores_seen];
		assert (dmem_req.addr == exp_addr)
			else report_mismatch("o_dmem.addr", exp_addr, dmem_req.addr);
		assert (dmem_req.wdata == exp_data)
			else report_mismatch("o_dmem.wdata", exp_data, dmem_req.wdata);
		mem[dmem_req.addr[12:2]] = dmem_req.wdata;
		stores_seen++;
	endtask

	// Strobes are stable at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			assert (!dmem_req.rd && !dmem_req.wr)
				else abort_run("data port strobe high during reset");
		end else begin
			if (!fetch_seen) begin
				assert (!dmem_req.rd && !dmem_req.wr)
					else abort_run("data port strobe high in the first cycle after reset");
				assert (imem_req.rd)
					else abort_run("no instruction fetch in the first cycle after reset");
				assert (imem_req.addr == 32'h0)
					else report_mismatch("o_imem.addr", 32'h0, imem_req.addr);
				fetch_seen = 1'b1;
			end
			if (dmem_req.wr)
				check_store();
		end
	end

	initial begin
		load_cases();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		wait (stores_seen == n_expected);
		if (n_expected > 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run("case file holds no expected stores");
		end
	end

	// Worst case per instruction with room for loops
	initial begin
		wait (loaded);
		#(MAX_INSTR_CYCLES * CYCLE_NS * LOOP_ALLOWANCE * n_prog);
		abort_run("timeout before all expected stores were seen");
	end

endmodule

/* bench/core_cases.txt */
# Tags: P program word, D initial data word, E expected store
# Columns: tag, byte address (hex), word (hex)
P 00000000 00001537
P 00000004 ff900093
P 00000008 00300113
# Register-register ops on x1 = -7, x2 = 3, each stored from x3
P 0000000c 002081b3
P 00000010 00352023
P 00000014 401101b3
P 00000018 00352223
P 0000001c 002091b3
P 00000020 00352423
P 00000024 0020a1b3
P 00000028 00352623
P 0000002c 0020b1b3
P 00000030 00352823
P 00000034 0020c1b3
P 00000038 00352a23
P 0000003c 0020d1b3
P 00000040 00352c23
P 00000044 4020d1b3
P 00000048 00352e23
P 0000004c 0020e1b3
P 00000050 02352023
P 00000054 0020f1b3
P 00000058 02352223
# srai, srli, addi with negative immediate, lui
P 0000005c 4020d193
P 00000060 02352423
P 00000064 0020d193
P 00000068 02352623
P 0000006c f9c10193
P 00000070 02352823
P 00000074 abcde1b7
P 00000078 02352a23
P 0000007c 10052403
P 00000080 10452483
P 00000084 00940433
P 00000088 10852423
# Branch pairs, not taken then taken, marker in x5
P 0000008c 05a00293
P 00000090 00208463
P 00000094 00210463
P 00000098 1002c293
P 0000009c 00211463
P 000000a0 00209463
P 000000a4 2002c293
P 000000a8 00114463
P 000000ac 0020c463
P 000000b0 4002c293
P 000000b4 0020d463
P 000000b8 00115463
P 000000bc 0012c293
P 000000c0 0020e463
P 000000c4 00116463
P 000000c8 0042c293
P 000000cc 00117463
P 000000d0 0020f463
P 000000d4 0202c293
P 000000d8 02552c23
P 000000dc 00300393
P 000000e0 00130313
P 000000e4 fe731ee3
P 000000e8 02652e23
P 000000ec 07f00013
P 000000f0 04052023
P 000000f4 00000063
D 00001100 90000001
D 00001104 80000003
E 00001000 fffffffc
E 00001004 0000000a
E 00001008 ffffffc8
E 0000100c 00000001
E 00001010 00000000
E 00001014 fffffffa
E 00001018 1fffffff
E 0000101c ffffffff
E 00001020 fffffffb
E 00001024 00000001
E 00001028 fffffffe
E 0000102c 3ffffffe
E 00001030 ffffff9f
E 00001034 abcde000
E 00001108 10000004
E 00001038 0000005a
E 0000103c 00000003
E 00001040 00000000

/* files.f */
+incdir+rtl
rtl/rv_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/control_fsm.sv
rtl/rv_core.sv
bench/tb_rv_core.sv
